// ==== hdl/mk14_params.svh ====
`ifndef MK14_PARAMS_SVH
`define MK14_PARAMS_SVH

// memory map
`define MK14_STD_RAM_BYTES   512      // standard ram from address 0
`define MK14_VDU_BASE_ADDR   16'h0200 // first byte of video ram
`define MK14_VDU_RAM_BYTES   1024

// horizontal timing in pixels
`define VDU_H_ACTIVE         256
`define VDU_H_FRONT          8
`define VDU_H_SYNC           32
`define VDU_H_BACK           24

// vertical timing in lines
`define VDU_V_ACTIVE         128
`define VDU_V_FRONT          2
`define VDU_V_SYNC           3
`define VDU_V_BACK           7

`define VDU_LINE_REPEAT      4        // scanlines per bitmap row
`define VDU_BYTES_PER_ROW    32

`endif

// ==== hdl/mk14_pkg.sv ====
`default_nettype none

package mk14_pkg;

	typedef logic [15:0] addr_t;  // host and vdu bus address
	typedef logic [7:0]  byte_t;
	typedef logic [8:0]  pix_x_t; // covers the whole 320 pixel line
	typedef logic [7:0]  pix_y_t; // covers the whole 140 line frame

	typedef struct packed {
		logic  we;
		logic  re;
		addr_t addr;
		byte_t wdata;
	} host_bus_t;

	typedef struct packed {
		logic  read_en;
		addr_t read_addr;
	} vdu_read_t;

	typedef struct packed {
		logic hsync; // active low
		logic vsync; // active low
		logic de;
	} vga_sync_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} vga_rgb_t;

endpackage

`default_nettype wire

// ==== hdl/mk14_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mk14_params.svh"

module mk14_mem
(
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire mk14_pkg::host_bus_t host_bus,
	output mk14_pkg::byte_t          rdata,     // valid the cycle after re
	input  wire mk14_pkg::vdu_read_t vdu_read,
	output mk14_pkg::byte_t          vdu_data   // valid the cycle after read_en
);

localparam int STD_AW = $clog2(`MK14_STD_RAM_BYTES);
localparam int VDU_AW = $clog2(`MK14_VDU_RAM_BYTES);

localparam mk14_pkg::addr_t VDU_BASE = mk14_pkg::addr_t'(`MK14_VDU_BASE_ADDR);
localparam mk14_pkg::addr_t VDU_END  =
	mk14_pkg::addr_t'(`MK14_VDU_BASE_ADDR + `MK14_VDU_RAM_BYTES);
localparam mk14_pkg::addr_t STD_END  = mk14_pkg::addr_t'(`MK14_STD_RAM_BYTES);

localparam mk14_pkg::byte_t OPEN_BUS = 8'hff; // unmapped reads float high

mk14_pkg::byte_t std_ram [`MK14_STD_RAM_BYTES];
mk14_pkg::byte_t vdu_ram [`MK14_VDU_RAM_BYTES];

logic            std_sel;
logic            vdu_sel;
mk14_pkg::addr_t host_vdu_off;
mk14_pkg::addr_t vdu_rd_off;

// host address decode
always_comb begin
	std_sel      = host_bus.addr < STD_END;
	vdu_sel      = (host_bus.addr >= VDU_BASE) && (host_bus.addr < VDU_END);
	host_vdu_off = host_bus.addr - VDU_BASE;
	vdu_rd_off   = vdu_read.read_addr - VDU_BASE;
end

// host writes that miss both rams are dropped
always_ff @(posedge clk) begin
	if (host_bus.we && std_sel) begin
		std_ram[host_bus.addr[STD_AW-1:0]] <= host_bus.wdata;
	end
	if (host_bus.we && vdu_sel) begin
		vdu_ram[host_vdu_off[VDU_AW-1:0]] <= host_bus.wdata;
	end
end

// host read port holds until the next re
always_ff @(posedge clk) begin
	if (host_bus.re) begin
		if (std_sel) begin
			rdata <= std_ram[host_bus.addr[STD_AW-1:0]];
		end else if (vdu_sel) begin
			rdata <= vdu_ram[host_vdu_off[VDU_AW-1:0]];
		end else begin
			rdata <= OPEN_BUS;
		end
	end
end

// second port of video ram, read only for the vdu
always_ff @(posedge clk) begin
	if (vdu_read.read_en) begin
		vdu_data <= vdu_ram[vdu_rd_off[VDU_AW-1:0]];
	end
end

// host bus never asks for both directions at once
a_host_we_re_excl: assert property (
	@(posedge clk) disable iff (!rst_n)
	!(host_bus.we && host_bus.re)
) else $error("host bus we and re high together");

// vdu reads only ever target video ram
a_vdu_read_range: assert property (
	@(posedge clk) disable iff (!rst_n)
	vdu_read.read_en |-> (vdu_read.read_addr >= VDU_BASE) &&
		(vdu_read.read_addr < VDU_END)
) else $error("vdu read outside video ram");

endmodule

`default_nettype wire

// ==== hdl/vdu_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mk14_params.svh"

module vdu_timing
(
	input  wire logic           clk,
	input  wire logic           rst_n,
	output mk14_pkg::vga_sync_t sync,
	output mk14_pkg::pix_x_t    pix_x,
	output mk14_pkg::pix_y_t    pix_y
);

// horizontal order is active, front porch, sync and back porch
localparam int H_SYNC_START = `VDU_H_ACTIVE + `VDU_H_FRONT;
localparam int H_SYNC_END   = H_SYNC_START + `VDU_H_SYNC;
localparam int H_TOTAL      = H_SYNC_END + `VDU_H_BACK;   // 320

// vertical order is the same in lines
localparam int V_SYNC_START = `VDU_V_ACTIVE + `VDU_V_FRONT;
localparam int V_SYNC_END   = V_SYNC_START + `VDU_V_SYNC;
localparam int V_TOTAL      = V_SYNC_END + `VDU_V_BACK;   // 140

mk14_pkg::pix_x_t h_cnt;
mk14_pkg::pix_y_t v_cnt;
logic             line_end;
logic             frame_end;

always_comb begin
	line_end  = (h_cnt == mk14_pkg::pix_x_t'(H_TOTAL - 1));
	frame_end = (v_cnt == mk14_pkg::pix_y_t'(V_TOTAL - 1));
end

// pixel counter
always_ff @(posedge clk) begin
	if (!rst_n) begin
		h_cnt <= '0;
	end else if (line_end) begin
		h_cnt <= '0;
	end else begin
		h_cnt <= h_cnt + 1'b1;
	end
end

// line counter steps at the end of each line
always_ff @(posedge clk) begin
	if (!rst_n) begin
		v_cnt <= '0;
	end else if (line_end) begin
		if (frame_end) begin
			v_cnt <= '0;
		end else begin
			v_cnt <= v_cnt + 1'b1;
		end
	end
end

// sync and active area decode straight from the counters
always_comb begin
	sync.hsync = !((h_cnt >= mk14_pkg::pix_x_t'(H_SYNC_START)) &&
		(h_cnt < mk14_pkg::pix_x_t'(H_SYNC_END)));
	sync.vsync = !((v_cnt >= mk14_pkg::pix_y_t'(V_SYNC_START)) &&
		(v_cnt < mk14_pkg::pix_y_t'(V_SYNC_END)));
	sync.de    = (h_cnt < mk14_pkg::pix_x_t'(`VDU_H_ACTIVE)) &&
		(v_cnt < mk14_pkg::pix_y_t'(`VDU_V_ACTIVE));
end

assign pix_x = h_cnt; // position is only meaningful while de is high
assign pix_y = v_cnt;

// active area stays clear of both sync pulses
a_de_outside_sync: assert property (
	@(posedge clk) disable iff (!rst_n)
	sync.de |-> (sync.hsync && sync.vsync)
) else $error("de high during sync");

endmodule

`default_nettype wire

// ==== hdl/vdu_bitmap.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mk14_params.svh"

module vdu_bitmap
(
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire mk14_pkg::vga_sync_t sync_in,
	input  wire mk14_pkg::pix_x_t    pix_x,
	input  wire mk14_pkg::pix_y_t    pix_y,
	output mk14_pkg::vdu_read_t      vdu_read,
	input  wire mk14_pkg::byte_t     vdu_data,
	output mk14_pkg::vga_sync_t      vga_sync,
	output mk14_pkg::vga_rgb_t       vga_rgb
);

localparam mk14_pkg::vga_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
localparam mk14_pkg::vga_rgb_t  RGB_WHITE = '{r: '1, g: '1, b: '1};
localparam mk14_pkg::vga_rgb_t  RGB_BLACK = '0;

mk14_pkg::addr_t     row_base;  // first byte of the bitmap row
mk14_pkg::addr_t     col_off;   // byte within the row
mk14_pkg::vga_sync_t sync_d1;
logic [2:0]          bit_d1;    // pixel within the byte with 0 leftmost
logic                pix_on;

// stage 0 gives the byte address for this pixel
always_comb begin
	row_base = mk14_pkg::addr_t'(pix_y / `VDU_LINE_REPEAT) *
		mk14_pkg::addr_t'(`VDU_BYTES_PER_ROW);
	col_off  = mk14_pkg::addr_t'(pix_x / 8);
	vdu_read.read_en   = sync_in.de;
	vdu_read.read_addr = mk14_pkg::addr_t'(`MK14_VDU_BASE_ADDR) + row_base + col_off;
end

// stage 1 holds sync alongside the ram read
always_ff @(posedge clk) begin
	if (!rst_n) begin
		sync_d1 <= SYNC_IDLE;
	end else begin
		sync_d1 <= sync_in;
	end
end

always_ff @(posedge clk) begin
	bit_d1 <= pix_x[2:0];
end

// msb of the byte is the leftmost pixel
assign pix_on = vdu_data[3'd7 - bit_d1];

// stage 2 registers the pixel and the delayed sync
always_ff @(posedge clk) begin
	if (!rst_n) begin
		vga_sync <= SYNC_IDLE;
		vga_rgb  <= RGB_BLACK;
	end else begin
		vga_sync <= sync_d1;
		if (sync_d1.de && pix_on) begin
			vga_rgb <= RGB_WHITE;
		end else begin
			vga_rgb <= RGB_BLACK; // blanking is black too
		end
	end
end

// blanking never carries colour
a_rgb_blank: assert property (
	@(posedge clk) disable iff (!rst_n)
	!vga_sync.de |-> (vga_rgb == RGB_BLACK)
) else $error("rgb not zero outside active area");

endmodule

`default_nettype wire

// ==== hdl/mk14_display_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mk14_display_top
(
	input  wire logic                clk,
	input  wire logic                rst_n,

	input  wire mk14_pkg::host_bus_t host_bus,  // plain strobes from the host
	output mk14_pkg::byte_t          rdata,

	output mk14_pkg::vga_sync_t      vga_sync,  // hsync, vsync, de
	output mk14_pkg::vga_rgb_t       vga_rgb    // 5:6:5 pixel
);

mk14_pkg::vga_sync_t tim_sync;   // timing stage ahead of the outputs
mk14_pkg::pix_x_t    tim_x;
mk14_pkg::pix_y_t    tim_y;

mk14_pkg::vdu_read_t vdu_read;   // read request into video ram
mk14_pkg::byte_t     vdu_data;   // display memory data

mk14_mem mk14_mem_inst (
	.clk,
	.rst_n,
	.host_bus,
	.rdata,
	.vdu_read,
	.vdu_data
);

vdu_timing vdu_timing_inst (
	.clk,
	.rst_n,
	.sync(tim_sync),
	.pix_x(tim_x),
	.pix_y(tim_y)
);

vdu_bitmap vdu_bitmap_inst (
	.clk,
	.rst_n,
	.sync_in(tim_sync),
	.pix_x(tim_x),
	.pix_y(tim_y),
	.vdu_read,
	.vdu_data,
	.vga_sync,
	.vga_rgb
);

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

initial begin
	clk = 1'b0;
end

always begin
	#(PERIOD_NS / 2) clk = ~clk; // free running
end

endmodule

`default_nettype wire

// ==== verif/tb_mk14_display.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mk14_params.svh"

module tb_mk14_display;

localparam int CLK_PERIOD_NS = 20;
localparam int RESET_CYCLES  = 10;
localparam int H_TOTAL = `VDU_H_ACTIVE + `VDU_H_FRONT + `VDU_H_SYNC + `VDU_H_BACK;
localparam int V_TOTAL = `VDU_V_ACTIVE + `VDU_V_FRONT + `VDU_V_SYNC + `VDU_V_BACK;
localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
localparam int H_SYNC_START = `VDU_H_ACTIVE + `VDU_H_FRONT;
localparam int V_SYNC_START = `VDU_V_ACTIVE + `VDU_V_FRONT;
// first blanking line after the picture counted from the vsync edge
localparam int BLANK_OFFSET =
	((`VDU_V_ACTIVE + V_TOTAL - V_SYNC_START) % V_TOTAL) * H_TOTAL;
localparam int NUM_OPS     = 14;
localparam int NUM_UPDATES = 8;
localparam int NUM_FRAMES  = 2;
localparam int WATCHDOG_CYCLES = 64 + RESET_CYCLES + 3 * NUM_OPS +
	2 * `MK14_VDU_RAM_BYTES + 2 * NUM_UPDATES + 3 * FRAME_CYCLES;

localparam mk14_pkg::addr_t VDU_BASE = mk14_pkg::addr_t'(`MK14_VDU_BASE_ADDR);
localparam mk14_pkg::addr_t VDU_END  =
	mk14_pkg::addr_t'(`MK14_VDU_BASE_ADDR + `MK14_VDU_RAM_BYTES);

typedef logic [$clog2(`MK14_VDU_RAM_BYTES)-1:0] vram_idx_t;

typedef struct packed {
	logic            is_read;
	mk14_pkg::addr_t addr;
	mk14_pkg::byte_t wdata;
	mk14_pkg::byte_t rdata_exp;
} host_op_t;

// each host operation holds read flag, address, write data and expected read data
localparam host_op_t HOST_OPS [NUM_OPS] = '{
	'{1'b0, 16'h0000, 8'ha5, 8'h00},
	'{1'b0, 16'h01ff, 8'h3c, 8'h00},
	'{1'b1, 16'h0000, 8'h00, 8'ha5},
	'{1'b1, 16'h01ff, 8'h00, 8'h3c},
	'{1'b0, 16'h0200, 8'h81, 8'h00}, // first video ram byte
	'{1'b0, 16'h05ff, 8'h7e, 8'h00}, // last video ram byte
	'{1'b1, 16'h0200, 8'h00, 8'h81},
	'{1'b1, 16'h05ff, 8'h00, 8'h7e},
	'{1'b0, 16'h0600, 8'h12, 8'h00}, // just past video ram
	'{1'b1, 16'h0600, 8'h00, 8'hff},
	'{1'b0, 16'h8000, 8'hc3, 8'h00}, // would alias address 0
	'{1'b1, 16'h8000, 8'h00, 8'hff},
	'{1'b1, 16'h0000, 8'h00, 8'ha5},
	'{1'b1, 16'h0200, 8'h00, 8'h81}
};

localparam mk14_pkg::host_bus_t BUS_IDLE  = '0;
localparam mk14_pkg::vga_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
localparam mk14_pkg::vga_rgb_t  RGB_BLACK = '0;
localparam mk14_pkg::vga_rgb_t  RGB_WHITE = '{r: 5'h1f, g: 6'h3f, b: 5'h1f};

logic                clk;
logic                rst_n;
mk14_pkg::host_bus_t host_bus;
mk14_pkg::byte_t     rdata;
mk14_pkg::vga_sync_t vga_sync;
mk14_pkg::vga_rgb_t  vga_rgb;

mk14_pkg::byte_t    model [`MK14_VDU_RAM_BYTES]; // mirror of video ram
mk14_pkg::vga_rgb_t row_buf [`VDU_H_ACTIVE];     // first scanline of each bitmap row
event               blank_start;

tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) i_clock (.clk);

mk14_display_top i_dut (
	.clk,
	.rst_n,
	.host_bus,
	.rdata,
	.vga_sync,
	.vga_rgb
);

task automatic stop_on_error(input string msg);
	$display("%s", msg);
	$display("Test failed");
	$fatal(1, "stopping at the first error");
endtask

task automatic check_byte(input mk14_pkg::byte_t got, input mk14_pkg::byte_t exp,
	input string what);
	if (got !== exp) begin
		stop_on_error($sformatf("FAILED at %0t ns: %s read 0x%02h, expected 0x%02h",
			$time, what, got, exp));
	end
endtask

task automatic check_sync(input mk14_pkg::vga_sync_t got, input mk14_pkg::vga_sync_t exp,
	input string what);
	if (got !== exp) begin
		stop_on_error($sformatf("FAILED at %0t ns: %s hsync/vsync/de %b, expected %b",
			$time, what, got, exp));
	end
endtask

task automatic check_rgb(input mk14_pkg::vga_rgb_t got, input mk14_pkg::vga_rgb_t exp,
	input string what);
	if (got !== exp) begin
		stop_on_error($sformatf("FAILED at %0t ns: %s rgb 0x%04h, expected 0x%04h",
			$time, what, got, exp));
	end
endtask

task automatic host_write(input mk14_pkg::addr_t addr, input mk14_pkg::byte_t data);
	@(posedge clk);
	host_bus <= '{we: 1'b1, re: 1'b0, addr: addr, wdata: data};
	@(posedge clk);
	host_bus <= BUS_IDLE;
	if (addr >= VDU_BASE && addr < VDU_END) begin
		model[vram_idx_t'(addr - VDU_BASE)] = data; // write has landed
	end
endtask

task automatic host_read(input mk14_pkg::addr_t addr, output mk14_pkg::byte_t data);
	@(posedge clk);
	host_bus <= '{we: 1'b0, re: 1'b1, addr: addr, wdata: 8'h00};
	@(posedge clk);
	host_bus <= BUS_IDLE;
	@(negedge clk);
	data = rdata;
endtask

task automatic wait_vsync_fall();
	logic prev;
	@(negedge clk);
	prev = vga_sync.vsync;
	@(negedge clk);
	while (!(prev && !vga_sync.vsync)) begin
		prev = vga_sync.vsync;
		@(negedge clk);
	end
endtask

// frame offset 0 is the first line of vsync at the outputs
task automatic check_frames(input int frames);
	int                  i;
	int                  fi;
	int                  x;
	int                  y;
	mk14_pkg::byte_t     pix_byte;
	mk14_pkg::vga_sync_t exp_sync;
	mk14_pkg::vga_rgb_t  exp_rgb;
	string               ctx;
	wait_vsync_fall();
	for (i = 0; i < frames * FRAME_CYCLES; i++) begin
		if (i > 0) begin
			@(negedge clk);
		end
		fi = i % FRAME_CYCLES;
		y  = (V_SYNC_START + fi / H_TOTAL) % V_TOTAL;
		x  = fi % H_TOTAL;
		if (i == BLANK_OFFSET) begin
			-> blank_start; // picture of the first frame is done
		end
		exp_sync.hsync = !(x >= H_SYNC_START && x < H_SYNC_START + `VDU_H_SYNC);
		exp_sync.vsync = !(y >= V_SYNC_START && y < V_SYNC_START + `VDU_V_SYNC);
		exp_sync.de    = (x < `VDU_H_ACTIVE) && (y < `VDU_V_ACTIVE);
		exp_rgb = RGB_BLACK;
		ctx = $sformatf("frame %0d line %0d pixel %0d", i / FRAME_CYCLES, y, x);
		if (exp_sync.de) begin
			if (y % `VDU_LINE_REPEAT == 0) begin
				pix_byte = model[vram_idx_t'((y / `VDU_LINE_REPEAT) * `VDU_BYTES_PER_ROW +
					x / 8)];
				if (pix_byte[3'(7 - x % 8)]) begin
					exp_rgb = RGB_WHITE; // msb is the leftmost pixel
				end
			end else begin
				exp_rgb = row_buf[x[7:0]];
				ctx = {ctx, " against first scanline of row"};
			end
		end
		check_sync(vga_sync, exp_sync, ctx);
		check_rgb(vga_rgb, exp_rgb, ctx);
		if (exp_sync.de && (y % `VDU_LINE_REPEAT == 0)) begin
			row_buf[x[7:0]] = vga_rgb;
		end
	end
endtask

// flip a few bytes while the first checked frame is blanking
task automatic update_vram();
	int k;
	int off;
	@(blank_start);
	for (k = 0; k < NUM_UPDATES; k++) begin
		off = $urandom % `MK14_VDU_RAM_BYTES;
		host_write(mk14_pkg::addr_t'(VDU_BASE + off), ~model[vram_idx_t'(off)]);
	end
endtask

initial begin
	int              i;
	host_op_t        op;
	mk14_pkg::byte_t got;
	void'($urandom(32'h15b7adf2));
	rst_n    = 1'b0;
	host_bus = BUS_IDLE;
	for (i = 0; i < RESET_CYCLES; i++) begin
		@(negedge clk);
		check_sync(vga_sync, SYNC_IDLE, "during reset");
		check_rgb(vga_rgb, RGB_BLACK, "during reset");
	end
	@(posedge clk);
	rst_n <= 1'b1;
	@(negedge clk);
	check_sync(vga_sync, SYNC_IDLE, "first cycle after reset"); // pipeline still filling
	check_rgb(vga_rgb, RGB_BLACK, "first cycle after reset");

	for (i = 0; i < NUM_OPS; i++) begin
		op = HOST_OPS[i];
		if (op.is_read) begin
			host_read(op.addr, got);
			check_byte(got, op.rdata_exp, $sformatf("host address 0x%04h", op.addr));
		end else begin
			host_write(op.addr, op.wdata);
		end
	end

	for (i = 0; i < `MK14_VDU_RAM_BYTES; i++) begin
		host_write(mk14_pkg::addr_t'(VDU_BASE + i), mk14_pkg::byte_t'($urandom));
	end

	fork
		check_frames(NUM_FRAMES);
		update_vram();
	join

	$display("Test completed successfully");
	$finish;
end

initial begin
	#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
	stop_on_error($sformatf("Watchdog expired after %0d cycles, checks did not finish",
		WATCHDOG_CYCLES));
end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/mk14_pkg.sv
hdl/mk14_mem.sv
hdl/vdu_timing.sv
hdl/vdu_bitmap.sv
hdl/mk14_display_top.sv
verif/tb_clock.sv
verif/tb_mk14_display.sv

// ==== Makefile ====
# Verilator flow for the MK14 display testbench

TOP := tb_mk14_display

.PHONY: all lint sim clean

all: sim

# lint the synthesizable top only
lint:
	verilator --lint-only --timing -f verilog.f --top-module mk14_display_top

# build and run, pass only when the pass message shows up
sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
